//--- dcache.f
dcache_pkg.sv
dcache_line_store.sv
dcache_refill_buffer.sv
dcache_ctrl.sv
dcache_write_ctrl.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -f dcache.f

out=$(./obj_dir/Vtb_dcache 2>&1 || true)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "No errors"

//--- tb_dcache.sv
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int MEM_WORDS   = 16384;
    localparam int RST_CYCLES  = 8;
    localparam int NUM_REQ     = 20;
    localparam int CYC_PER_REQ = 200;

    localparam logic [31:0] ADDR_A = 32'h0000_0440;
    localparam logic [31:0] ADDR_B = 32'h0000_2440;    // Same index as A, next tag
    localparam logic [31:0] ADDR_U = 32'h0000_8020;    // Only ever accessed uncached
    localparam logic [31:0] ADDR_C = 32'h0000_3084;

    logic         clk;
    logic         rst;
    logic         den;
    logic [3:0]   dwen;
    dcache_addr_u daddr_psy;
    logic [31:0]  wdata;
    logic         daddr_type;
    wire          data_ok;
    wire  [31:0]  data_data;
    wire          mmu_running;
    wire  [31:0]  daddr_req;
    wire          read_en;
    wire          read_type;
    logic         daddr_req_ok;
    logic [31:0]  ddata_rdata;
    logic         ddata_rvalid;
    logic         ddata_rlast;
    wire  [31:0]  daddr_wreq;
    wire          write_en;
    wire          write_type;
    wire  [3:0]   write_byte_en;
    wire          dwvalid;
    wire  [31:0]  dwdata;
    wire          dwlast;
    logic         daddr_wreq_ok;
    logic         ddata_wready;
    logic         ddata_bvalid;

    logic [31:0] mem    [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];  // Memory as the processor should see it
    integer      seed;
    int          errors;
    int          checks;

    dcache_top dcache_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h0001_0193) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic int word_idx(input logic [31:0] addr);
        return int'(addr[15:2]);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Expected read word for any address
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return shadow[word_idx(addr)];
    endfunction

    task automatic ref_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        shadow[word_idx(addr)] = merge_bytes(shadow[word_idx(addr)], data, be);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // Read bus side of the memory model
    task automatic serve_reads();
        logic [31:0] base;
        int          beats;
        int          delay;
        forever begin
            @(posedge clk);
            if (read_en) begin
                base  = daddr_req;
                check("read_type", read_type, daddr_type ? BUS_UNCACHED : BUS_CACHED);
                check("daddr_req", daddr_req,
                      daddr_type ? daddr_psy.raw : (daddr_psy.raw & ~32'h0000_003f));
                beats = (read_type == BUS_UNCACHED) ? 1 : LINE_WORDS;
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                #1 daddr_req_ok = 1'b1;
                @(posedge clk);
                #1 daddr_req_ok = 1'b0;
                for (int b = 0; b < beats; b++) begin
                    ddata_rvalid = 1'b1;
                    ddata_rdata  = mem[word_idx(base) + b];
                    ddata_rlast  = (b == beats - 1);
                    @(posedge clk);
                    #1;
                end
                ddata_rvalid = 1'b0;
                ddata_rlast  = 1'b0;
            end
        end
    endtask

    // Write bus side, applies each accepted beat to the array
    task automatic serve_writes();
        logic [31:0] base;
        logic [3:0]  be;
        int          beat;
        int          delay;
        logic        done;
        forever begin
            @(posedge clk);
            if (write_en) begin
                base  = daddr_wreq;
                be    = write_byte_en;  // Only valid with the request
                check("write_type", write_type, daddr_type ? BUS_UNCACHED : BUS_CACHED);
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                #1 daddr_wreq_ok = 1'b1;
                @(posedge clk);
                #1 daddr_wreq_ok = 1'b0;
                beat = 0;
                done = 1'b0;
                while (!done) begin
                    delay = $random(seed) & 3;
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                    ddata_wready = 1'b1;
                    @(posedge clk);
                    if (dwvalid) begin
                        mem[word_idx(base) + beat] =
                            merge_bytes(mem[word_idx(base) + beat], dwdata, be);
                        done = dwlast;
                        beat++;
                    end
                    #1 ddata_wready = 1'b0;
                end
                ddata_bvalid = 1'b1;
                @(posedge clk);
                #1 ddata_bvalid = 1'b0;
            end
        end
    endtask

    // One processor request, held until data_ok
    task automatic access(input logic [31:0] addr, input logic uncached, input logic [3:0] be,
                          input logic [31:0] data, input logic expect_hit);
        int lat;
        lat        = 0;
        den        = 1'b1;
        dwen       = be;
        daddr_psy  = addr;
        wdata      = data;
        daddr_type = uncached;
        @(posedge clk);
        while (!data_ok) begin
            check("mmu_running", mmu_running, 1'b1);   // Busy until answered
            lat++;
            @(posedge clk);
        end
        if (expect_hit) begin
            check("data_ok latency", lat, 0);
            check("mmu_running", mmu_running, 1'b0);
        end
        #1;
        den        = 1'b0;
        dwen       = 4'b0000;
        daddr_type = 1'b0;
        if (be != 4'b0000) begin
            ref_write(addr, data, be);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_tests();
        logic [31:0] rnd;
        access(ADDR_A + 32'h14, 1'b0, 4'b0000, '0, 1'b0);
        access(ADDR_A + 32'h18, 1'b0, 4'b0000, '0, 1'b1);
        access(ADDR_A + 32'h14, 1'b0, 4'b0101, 32'hdead_beef, 1'b1);
        access(ADDR_A + 32'h14, 1'b0, 4'b0000, '0, 1'b1);

        // Conflict miss pushes the dirty A line out
        access(ADDR_B + 32'h14, 1'b0, 4'b0000, '0, 1'b0);
        for (int w = 0; w < LINE_WORDS; w++) begin
            check("mem", mem[word_idx(ADDR_A) + w], ref_read(ADDR_A + 4 * w));
        end
        access(ADDR_A + 32'h14, 1'b0, 4'b0000, '0, 1'b0);

        access(ADDR_U, 1'b1, 4'b0000, '0, 1'b0);
        mem[word_idx(ADDR_U)]    = 32'h0bad_cafe;   // Changed behind the cache
        shadow[word_idx(ADDR_U)] = 32'h0bad_cafe;
        access(ADDR_U, 1'b1, 4'b0000, '0, 1'b0);
        access(ADDR_U, 1'b1, 4'b1100, 32'h1122_3344, 1'b0);
        access(ADDR_U, 1'b1, 4'b0000, '0, 1'b0);

        access(ADDR_C, 1'b0, 4'b0011, 32'hcafe_f00d, 1'b0);
        access(ADDR_C, 1'b0, 4'b0000, '0, 1'b1);

        // Cached reads below the uncached window
        for (int n = 0; n < 8; n++) begin
            rnd = $random(seed) & 32'h0000_7ffc;
            access(rnd, 1'b0, 4'b0000, '0, 1'b0);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && den && data_ok && dwen == 4'b0000) begin
            check("data_data", data_data, ref_read(daddr_psy.raw));
        end
    end

    initial begin
        seed          = 99;
        errors        = 0;
        checks        = 0;
        rst           = 1'b1;
        den           = 1'b0;
        dwen          = 4'b0000;
        daddr_psy     = '0;
        wdata         = '0;
        daddr_type    = 1'b0;
        daddr_req_ok  = 1'b0;
        ddata_rdata   = '0;
        ddata_rvalid  = 1'b0;
        ddata_rlast   = 1'b0;
        daddr_wreq_ok = 1'b0;
        ddata_wready  = 1'b0;
        ddata_bvalid  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = mem[i];
        end
        fork
            serve_reads();
            serve_writes();
        join_none
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;
        run_tests();
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (RST_CYCLES + CYC_PER_REQ * NUM_REQ) @(posedge clk);
        $display("Timeout: the requests did not complete in %0d cycles", CYC_PER_REQ * NUM_REQ);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache_assertions.sv
`default_nettype none

module dcache_assertions (
    input wire clk,
    input wire rst,
    input wire read_en,
    input wire write_en,
    input wire mmu_running,
    input wire dwvalid,
    input wire dwlast
);

    last_needs_valid: assert property (@(posedge clk) disable iff (rst) dwlast |-> dwvalid)
        else $error("dwlast raised without dwvalid");

    // Bus reads only happen on the slow path
    read_while_busy: assert property (@(posedge clk) disable iff (rst) read_en |-> mmu_running)
        else $error("read_en high while mmu_running is low");

    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !read_en && !write_en)
        else $error("bus request active in the first cycle after reset");

endmodule

bind dcache_top dcache_assertions dcache_assertions_inst (.*);

`default_nettype wire

//--- dcache_top.sv
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,

    // Processor port
    input  wire                 den,
    input  wire [BE_W-1:0]      dwen,
    input  wire dcache_addr_u   daddr_psy,
    input  wire [WORD_W-1:0]    wdata,
    input  wire                 daddr_type,     // 1 for uncached
    output wire                 data_ok,
    output wire [WORD_W-1:0]    data_data,
    output wire                 mmu_running,

    // Read bus
    output wire [WORD_W-1:0]    daddr_req,
    output wire                 read_en,
    output wire                 read_type,
    input  wire                 daddr_req_ok,
    input  wire [WORD_W-1:0]    ddata_rdata,
    input  wire                 ddata_rvalid,
    input  wire                 ddata_rlast,

    // Write bus
    output wire [WORD_W-1:0]    daddr_wreq,
    output wire                 write_en,
    output wire                 write_type,
    output wire [BE_W-1:0]      write_byte_en,
    output wire                 dwvalid,
    output wire [WORD_W-1:0]    dwdata,
    output wire                 dwlast,
    input  wire                 daddr_wreq_ok,
    input  wire                 ddata_wready,
    input  wire                 ddata_bvalid
);

    wire                               hit;
    wire                               victim_dirty;
    wire [TAG_W-1:0]                   victim_tag;
    wire [LINE_WORDS-1:0][WORD_W-1:0]  line_words;
    wire [LINE_WORDS-1:0][WORD_W-1:0]  refill_words;
    wire                               capture;
    wire                               store_we;
    wire                               refill_sel;
    wire                               wr_start;
    wire                               wr_uncached;
    wire                               wr_idle;
    wire                               wr_done;

    dcache_ctrl dcache_ctrl_inst (.*);

    dcache_write_ctrl dcache_write_ctrl_inst (.*);

    dcache_line_store dcache_line_store_inst (
        .addr       (daddr_psy),
        .wr_offset  (daddr_psy.fields.offset),
        .*
    );

    dcache_refill_buffer dcache_refill_buffer_inst (.*);

endmodule

`default_nettype wire

//--- dcache_write_ctrl.sv
`default_nettype none

module dcache_write_ctrl
    import dcache_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 wr_start,
    input  wire                                 wr_uncached,
    input  wire dcache_addr_u                   daddr_psy,
    input  wire [BE_W-1:0]                      dwen,
    input  wire [WORD_W-1:0]                    wdata,
    input  wire [TAG_W-1:0]                     victim_tag,
    input  wire [LINE_WORDS-1:0][WORD_W-1:0]    line_words,
    input  wire                                 daddr_wreq_ok,
    input  wire                                 ddata_wready,
    input  wire                                 ddata_bvalid,
    output logic [WORD_W-1:0]                   daddr_wreq,
    output logic                                write_en,
    output logic                                write_type,
    output logic [BE_W-1:0]                     write_byte_en,
    output logic                                dwvalid,
    output logic [WORD_W-1:0]                   dwdata,
    output logic                                dwlast,
    output logic                                wr_idle,
    output logic                                wr_done
);

    localparam logic [2:0] W_IDLE     = 3'd0;
    localparam logic [2:0] W_C_SHAKE  = 3'd1;
    localparam logic [2:0] W_C_WRITE  = 3'd2;
    localparam logic [2:0] W_C_RESULT = 3'd3;
    localparam logic [2:0] W_U_SHAKE  = 3'd4;
    localparam logic [2:0] W_U_WRITE  = 3'd5;
    localparam logic [2:0] W_U_RESULT = 3'd6;

    logic [2:0]          state;
    logic [2:0]          next_state;
    logic [OFFSET_W-1:0] beat_cnt;
    dcache_addr_u        victim_addr;

    // Line base of the line being evicted
    always_comb begin
        victim_addr                 = daddr_psy;
        victim_addr.fields.tag      = victim_tag;
        victim_addr.fields.offset   = '0;
        victim_addr.fields.byte_sel = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != W_C_WRITE) begin
            beat_cnt <= '0;
        end else if (ddata_wready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign wr_idle = (state == W_IDLE);
    assign wr_done = ((state == W_C_RESULT) || (state == W_U_RESULT)) && ddata_bvalid;

    always_comb begin
        next_state    = state;
        daddr_wreq    = '0;
        write_en      = 1'b0;
        write_type    = BUS_CACHED;
        write_byte_en = '0;
        dwvalid       = 1'b0;
        dwdata        = '0;
        dwlast        = 1'b0;

        case (state)
            W_IDLE: begin
                if (wr_start) begin
                    next_state = wr_uncached ? W_U_SHAKE : W_C_SHAKE;
                end
            end
            W_C_SHAKE: begin
                daddr_wreq    = victim_addr.raw;
                write_en      = 1'b1;
                write_byte_en = {BE_W{1'b1}};
                if (daddr_wreq_ok) begin
                    next_state = W_C_WRITE;
                end
            end
            W_C_WRITE: begin
                write_byte_en = {BE_W{1'b1}};
                dwvalid       = 1'b1;
                dwdata        = line_words[beat_cnt];  // Store is untouched until refill
                dwlast        = &beat_cnt;
                if (dwlast && ddata_wready) begin
                    next_state = W_C_RESULT;
                end
            end
            W_U_SHAKE: begin
                daddr_wreq    = daddr_psy.raw;
                write_en      = 1'b1;
                write_type    = BUS_UNCACHED;
                write_byte_en = dwen;
                if (daddr_wreq_ok) begin
                    next_state = W_U_WRITE;
                end
            end
            W_U_WRITE: begin
                write_byte_en = dwen;
                dwvalid       = 1'b1;
                dwdata        = wdata;
                dwlast        = 1'b1;   // Single beat
                if (ddata_wready) begin
                    next_state = W_U_RESULT;
                end
            end
            W_C_RESULT, W_U_RESULT: begin
                if (ddata_bvalid) begin
                    next_state = W_IDLE;
                end
            end
            default: begin
                next_state = W_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dcache_ctrl.sv
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 den,
    input  wire [BE_W-1:0]                      dwen,
    input  wire dcache_addr_u                   daddr_psy,
    input  wire                                 daddr_type,
    input  wire [WORD_W-1:0]                    wdata,
    input  wire                                 hit,
    input  wire                                 victim_dirty,
    input  wire [LINE_WORDS-1:0][WORD_W-1:0]    line_words,
    input  wire                                 daddr_req_ok,
    input  wire                                 ddata_rvalid,
    input  wire [WORD_W-1:0]                    ddata_rdata,
    input  wire                                 ddata_rlast,
    input  wire                                 wr_idle,
    input  wire                                 wr_done,
    input  wire [LINE_WORDS-1:0][WORD_W-1:0]    refill_words,
    output logic                                data_ok,
    output logic [WORD_W-1:0]                   data_data,
    output logic                                mmu_running,
    output logic [WORD_W-1:0]                   daddr_req,
    output logic                                read_en,
    output logic                                read_type,
    output logic                                capture,
    output logic                                store_we,
    output logic                                refill_sel,
    output logic                                wr_start,
    output logic                                wr_uncached
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_C_SHAKE  = 3'd1;
    localparam logic [2:0] S_C_WAIT   = 3'd2;
    localparam logic [2:0] S_C_WWAIT  = 3'd3;
    localparam logic [2:0] S_REFILL   = 3'd4;
    localparam logic [2:0] S_U_SHAKE  = 3'd5;
    localparam logic [2:0] S_U_RETURN = 3'd6;
    localparam logic [2:0] S_U_WWAIT  = 3'd7;

    logic [2:0]   state;
    logic [2:0]   next_state;
    logic         is_write;
    dcache_addr_u line_addr;

    assign is_write = |dwen;
    assign capture  = (state == S_C_WAIT);

    always_comb begin
        line_addr                 = daddr_psy;
        line_addr.fields.offset   = '0;
        line_addr.fields.byte_sel = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        data_ok     = 1'b0;
        data_data   = '0;
        mmu_running = 1'b0;
        daddr_req   = '0;
        read_en     = 1'b0;
        read_type   = BUS_CACHED;
        store_we    = 1'b0;
        refill_sel  = 1'b0;
        wr_start    = 1'b0;
        wr_uncached = 1'b0;

        case (state)
            S_IDLE: begin
                if (den && daddr_type) begin
                    mmu_running = 1'b1;
                    if (is_write) begin
                        wr_start    = 1'b1;
                        wr_uncached = 1'b1;
                        next_state  = S_U_WWAIT;
                    end else begin
                        daddr_req  = daddr_psy.raw;
                        read_en    = 1'b1;
                        read_type  = BUS_UNCACHED;
                        next_state = daddr_req_ok ? S_U_RETURN : S_U_SHAKE;
                    end
                end else if (den && hit) begin
                    data_ok = 1'b1;
                    if (is_write) begin
                        store_we  = 1'b1;   // Byte merge lands at the next edge
                        data_data = wdata;
                    end else begin
                        data_data = line_words[daddr_psy.fields.offset];
                    end
                end else if (den) begin
                    // Miss, a dirty victim goes out on the write bus meanwhile
                    mmu_running = 1'b1;
                    daddr_req   = line_addr.raw;
                    read_en     = 1'b1;
                    wr_start    = victim_dirty;
                    next_state  = daddr_req_ok ? S_C_WAIT : S_C_SHAKE;
                end
            end
            S_C_SHAKE: begin
                mmu_running = 1'b1;
                daddr_req   = line_addr.raw;
                read_en     = 1'b1;
                if (daddr_req_ok) begin
                    next_state = S_C_WAIT;
                end
            end
            S_C_WAIT: begin
                mmu_running = 1'b1;
                if (ddata_rvalid && ddata_rlast) begin
                    next_state = wr_idle ? S_REFILL : S_C_WWAIT;
                end
            end
            S_C_WWAIT: begin
                mmu_running = 1'b1;     // Victim still draining
                if (wr_idle) begin
                    next_state = S_REFILL;
                end
            end
            S_REFILL: begin
                mmu_running = 1'b1;
                store_we    = 1'b1;
                refill_sel  = 1'b1;
                data_ok     = !is_write;    // Writes retry as a hit
                data_data   = refill_words[daddr_psy.fields.offset];
                next_state  = S_IDLE;
            end
            S_U_SHAKE: begin
                mmu_running = 1'b1;
                daddr_req   = daddr_psy.raw;
                read_en     = 1'b1;
                read_type   = BUS_UNCACHED;
                if (daddr_req_ok) begin
                    next_state = S_U_RETURN;
                end
            end
            S_U_RETURN: begin
                mmu_running = 1'b1;
                data_ok     = ddata_rvalid;
                data_data   = ddata_rdata;
                if (ddata_rvalid && ddata_rlast) begin
                    next_state = S_IDLE;
                end
            end
            S_U_WWAIT: begin
                mmu_running = 1'b1;
                if (wr_done) begin
                    data_ok    = 1'b1;
                    data_data  = wdata;
                    next_state = S_IDLE;
                end
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dcache_refill_buffer.sv
`default_nettype none

module dcache_refill_buffer
    import dcache_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 capture,
    input  wire                                 ddata_rvalid,
    input  wire [WORD_W-1:0]                    ddata_rdata,
    output logic [LINE_WORDS-1:0][WORD_W-1:0]   refill_words
);

    logic [OFFSET_W-1:0] beat_cnt;

    // Restarts at word 0 for every burst
    always_ff @(posedge clk) begin
        if (rst || !capture) begin
            beat_cnt <= '0;
        end else if (ddata_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refill_words <= '0;
        end else if (capture && ddata_rvalid) begin
            refill_words[beat_cnt] <= ddata_rdata;
        end
    end

endmodule

`default_nettype wire

//--- dcache_line_store.sv
`default_nettype none

module dcache_line_store
    import dcache_pkg::*;
(
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire dcache_addr_u                   addr,
    input  wire                                 store_we,
    input  wire                                 refill_sel,
    input  wire [LINE_WORDS-1:0][WORD_W-1:0]    refill_words,
    input  wire [WORD_W-1:0]                    wdata,
    input  wire [BE_W-1:0]                      dwen,
    input  wire [OFFSET_W-1:0]                  wr_offset,
    output logic                                hit,
    output logic                                victim_dirty,
    output logic [TAG_W-1:0]                    victim_tag,
    output logic [LINE_WORDS-1:0][WORD_W-1:0]   line_words
);

    logic [LINE_WORDS-1:0][WORD_W-1:0] data_mem [LINE_COUNT];
    logic [TAG_W-1:0]                  tag_mem  [LINE_COUNT];
    logic [LINE_COUNT-1:0]             valid;
    logic [LINE_COUNT-1:0]             dirty;
    logic [INDEX_W-1:0]                index;
    logic [WORD_W-1:0]                 merged_word;

    assign index = addr.fields.index;

    // Asynchronous read of the indexed line
    assign line_words   = data_mem[index];
    assign victim_tag   = tag_mem[index];
    assign victim_dirty = dirty[index];
    assign hit          = valid[index] && (victim_tag == addr.fields.tag);

    always_comb begin
        merged_word = line_words[wr_offset];
        for (int b = 0; b < BE_W; b++) begin
            if (dwen[b]) begin
                merged_word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_we) begin
            if (refill_sel) begin
                data_mem[index] <= refill_words;    // Whole line from the bus
                tag_mem[index]  <= addr.fields.tag;
            end else begin
                data_mem[index][wr_offset] <= merged_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (store_we) begin
            if (refill_sel) begin
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0;   // Fresh copy of memory
            end else begin
                dirty[index] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 16;
    localparam int LINE_COUNT = 128;
    localparam int TAG_W      = 19;
    localparam int BE_W       = 4;

    localparam int INDEX_W  = $clog2(LINE_COUNT);
    localparam int OFFSET_W = $clog2(LINE_WORDS);
    localparam int BYTE_W   = $clog2(BE_W);    // Byte select within a word

    // read_type / write_type codes
    localparam logic BUS_CACHED   = 1'b0;
    localparam logic BUS_UNCACHED = 1'b1;

    // Physical address, raw or split for the cache lookup
    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
            logic [BYTE_W-1:0]   byte_sel;
        } fields;
    } dcache_addr_u;

endpackage

`default_nettype wire
